/* src/cpu_pkg.sv */
// Widths, memory depths and encodings for the RV64 subset core; only add, sub, and, or, addi, ld, sd
package cpu_pkg;

   // Datapath widths
   localparam int xlen       = 64;
   localparam int ilen       = 32;
   localparam int reg_addr_w = 5;
   localparam int opcode_w   = 7;

   // 512 instruction words, byte address bits [10:2]
   localparam int imem_addr_w = 9;
   // 1024 doublewords, byte address bits [12:3]
   localparam int dmem_addr_w = 10;

   // Instruction field positions
   localparam int rd_lsb     = 7;
   localparam int funct3_lsb = 12;
   localparam int rs1_lsb    = 15;
   localparam int rs2_lsb    = 20;
   localparam int funct7_lsb = 25;

   localparam logic [6:0] funct7_sub = 7'b0100000;

   localparam logic [2:0] funct3_add = 3'b000;
   localparam logic [2:0] funct3_or  = 3'b110;
   localparam logic [2:0] funct3_and = 3'b111;

   typedef enum logic [opcode_w-1:0] {
      op_rtype = 7'b0110011,
      op_itype = 7'b0010011,
      op_load  = 7'b0000011,
      op_store = 7'b0100011
   } opcode_e;

   // Operation class from decode; add is also the value of a bubble
   typedef enum logic [1:0] {
      alu_op_add   = 2'b00,
      alu_op_rtype = 2'b10,
      alu_op_itype = 2'b11
   } alu_op_e;

   typedef enum logic [3:0] {
      alu_and = 4'b0000,
      alu_or  = 4'b0001,
      alu_add = 4'b0010,
      alu_sub = 4'b0110
   } alu_ctrl_e;

   typedef enum logic [1:0] {
      fwd_none = 2'b00,
      fwd_wb   = 2'b01,
      fwd_mem  = 2'b10
   } fwd_sel_e;

endpackage

/* src/sram_dual_port.sv */
// Array has no reset; host port must not be used while the core runs, external write wins a tie
module sram_dual_port #(
   parameter int data_w = 32,
   parameter int addr_w = 9
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [cpu_pkg::xlen-1:0] addr,
   input  logic                     wen,
   input  logic [data_w-1:0]        wdata,
   output logic [data_w-1:0]        rdata,
   input  logic [cpu_pkg::xlen-1:0] addr_ext,
   input  logic                     wen_ext,
   input  logic                     ren_ext,
   input  logic [data_w-1:0]        wdata_ext,
   output logic [data_w-1:0]        rdata_ext
);

   // Byte offset bits dropped from the address
   localparam int byte_off = $clog2(data_w / 8);

   logic [data_w-1:0] mem [2**addr_w];
   logic [addr_w-1:0] idx;
   logic [addr_w-1:0] idx_ext;

   assign idx     = addr[byte_off +: addr_w];
   assign idx_ext = addr_ext[byte_off +: addr_w];

   // Core side read is combinational
   assign rdata = mem[idx];

   always_ff @(posedge clk) begin
      if (wen) begin
         mem[idx] <= wdata;
      end
      // Later assignment, so the host takes priority
      if (wen_ext) begin
         mem[idx_ext] <= wdata_ext;
      end
   end

   // Host read is registered and holds when not strobed
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rdata_ext <= '0;
      end else if (ren_ext) begin
         rdata_ext <= mem[idx_ext];
      end
   end

endmodule

/* src/register_file.sv */
// x0 reads zero and ignores writes; a same-cycle write is passed through to both read ports
module register_file (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           enable,
   input  logic                           reg_write,
   input  logic [cpu_pkg::reg_addr_w-1:0] raddr_1,
   input  logic [cpu_pkg::reg_addr_w-1:0] raddr_2,
   input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
   input  logic [cpu_pkg::xlen-1:0]       wdata,
   output logic [cpu_pkg::xlen-1:0]       rdata_1,
   output logic [cpu_pkg::xlen-1:0]       rdata_2
);
   import cpu_pkg::*;

   logic [xlen-1:0] regs [2**reg_addr_w];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 2**reg_addr_w; i++) begin
            regs[i] <= '0;
         end
      end else if (enable && reg_write && (waddr != '0)) begin
         regs[waddr] <= wdata;
      end
   end

   // Write-through lets decode see the result being written back
   assign rdata_1 = (raddr_1 == '0) ? '0 :
                    (reg_write && (raddr_1 == waddr)) ? wdata : regs[raddr_1];
   assign rdata_2 = (raddr_2 == '0) ? '0 :
                    (reg_write && (raddr_2 == waddr)) ? wdata : regs[raddr_2];

endmodule

/* src/fetch_stage.sv */
// The pc only steps by 4 or holds; no branches, so instruction memory is read at the pc every cycle
module fetch_stage (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     enable,
   input  logic                     stall,
   input  logic [cpu_pkg::xlen-1:0] addr_ext,
   input  logic                     wen_ext,
   input  logic                     ren_ext,
   input  logic [cpu_pkg::ilen-1:0] wdata_ext,
   output logic [cpu_pkg::ilen-1:0] rdata_ext,
   output logic [cpu_pkg::ilen-1:0] if_id_instr,
   output logic [cpu_pkg::xlen-1:0] if_id_pc
);
   import cpu_pkg::*;

   logic [xlen-1:0] pc;
   logic [ilen-1:0] instr;

   sram_dual_port #(
      .data_w(ilen),
      .addr_w(imem_addr_w)
   ) instr_mem (
      .clk      (clk),
      .arst_n   (arst_n),
      .addr     (pc),
      .wen      (1'b0),
      .wdata    ('0),
      .rdata    (instr),
      .addr_ext (addr_ext),
      .wen_ext  (wen_ext),
      .ren_ext  (ren_ext),
      .wdata_ext(wdata_ext),
      .rdata_ext(rdata_ext)
   );

   // pc and IF/ID hold together on a load-use stall
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc          <= '0;
         if_id_instr <= '0;
         if_id_pc    <= '0;
      end else if (enable && !stall) begin
         pc          <= pc + xlen'(4);
         if_id_instr <= instr;
         if_id_pc    <= pc;
      end
   end

endmodule

/* src/decode_stage.sv */
// Unknown opcodes decode to zero controls (a nop); stall is a level read back by fetch the same cycle
module decode_stage (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           enable,
   input  logic [cpu_pkg::ilen-1:0]       if_id_instr,
   input  logic [cpu_pkg::xlen-1:0]       if_id_pc,
   input  logic                           wb_reg_write,
   input  logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
   input  logic [cpu_pkg::xlen-1:0]       wb_data,
   output logic                           stall,
   output cpu_pkg::alu_op_e               alu_op,
   output logic                           alu_src,
   output logic                           mem_read,
   output logic                           mem_write,
   output logic                           mem_to_reg,
   output logic                           reg_write,
   output logic [cpu_pkg::xlen-1:0]       rs1_data,
   output logic [cpu_pkg::xlen-1:0]       rs2_data,
   output logic [cpu_pkg::xlen-1:0]       imm,
   output logic [cpu_pkg::reg_addr_w-1:0] rs1,
   output logic [cpu_pkg::reg_addr_w-1:0] rs2,
   output logic [cpu_pkg::reg_addr_w-1:0] rd,
   output logic [2:0]                     funct3,
   output logic [6:0]                     funct7
);
   import cpu_pkg::*;

   logic [reg_addr_w-1:0] dec_rs1;
   logic [reg_addr_w-1:0] dec_rs2;
   logic [reg_addr_w-1:0] dec_rd;
   logic [xlen-1:0]       dec_imm;
   logic [xlen-1:0]       rdata_1;
   logic [xlen-1:0]       rdata_2;
   alu_op_e               dec_alu_op;
   logic                  dec_alu_src;
   logic                  dec_mem_read;
   logic                  dec_mem_write;
   logic                  dec_mem_to_reg;
   logic                  dec_reg_write;

   assign dec_rs1 = if_id_instr[rs1_lsb +: reg_addr_w];
   assign dec_rs2 = if_id_instr[rs2_lsb +: reg_addr_w];
   assign dec_rd  = if_id_instr[rd_lsb +: reg_addr_w];

   register_file regs (
      .clk      (clk),
      .arst_n   (arst_n),
      .enable   (enable),
      .reg_write(wb_reg_write),
      .raddr_1  (dec_rs1),
      .raddr_2  (dec_rs2),
      .waddr    (wb_rd),
      .wdata    (wb_data),
      .rdata_1  (rdata_1),
      .rdata_2  (rdata_2)
   );

   // Load in EX whose result the instruction in ID needs
   assign stall = mem_read && (rd != '0) && ((rd == dec_rs1) || (rd == dec_rs2));

   // Store immediate is split, everything else uses the I-type field
   always_comb begin
      if (opcode_e'(if_id_instr[opcode_w-1:0]) == op_store) begin
         dec_imm = {{(xlen-12){if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
      end else begin
         dec_imm = {{(xlen-12){if_id_instr[31]}}, if_id_instr[31:20]};
      end
   end

   always_comb begin
      dec_alu_op     = alu_op_add;
      dec_alu_src    = 1'b0;
      dec_mem_read   = 1'b0;
      dec_mem_write  = 1'b0;
      dec_mem_to_reg = 1'b0;
      dec_reg_write  = 1'b0;
      case (opcode_e'(if_id_instr[opcode_w-1:0]))
         op_rtype: begin
            dec_alu_op    = alu_op_rtype;
            dec_reg_write = 1'b1;
         end
         op_itype: begin
            dec_alu_op    = alu_op_itype;
            dec_alu_src   = 1'b1;
            dec_reg_write = 1'b1;
         end
         op_load: begin
            dec_alu_src    = 1'b1;
            dec_mem_read   = 1'b1;
            dec_mem_to_reg = 1'b1;
            dec_reg_write  = 1'b1;
         end
         op_store: begin
            dec_alu_src   = 1'b1;
            dec_mem_write = 1'b1;
         end
         default: ;
      endcase
      // Bubble into ID/EX
      if (stall) begin
         dec_alu_op     = alu_op_add;
         dec_alu_src    = 1'b0;
         dec_mem_read   = 1'b0;
         dec_mem_write  = 1'b0;
         dec_mem_to_reg = 1'b0;
         dec_reg_write  = 1'b0;
      end
   end

   // ID/EX controls and indices
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         alu_op     <= alu_op_add;
         alu_src    <= 1'b0;
         mem_read   <= 1'b0;
         mem_write  <= 1'b0;
         mem_to_reg <= 1'b0;
         reg_write  <= 1'b0;
         rs1        <= '0;
         rs2        <= '0;
         rd         <= '0;
      end else if (enable) begin
         alu_op     <= dec_alu_op;
         alu_src    <= dec_alu_src;
         mem_read   <= dec_mem_read;
         mem_write  <= dec_mem_write;
         mem_to_reg <= dec_mem_to_reg;
         reg_write  <= dec_reg_write;
         rs1        <= dec_rs1;
         rs2        <= dec_rs2;
         rd         <= dec_rd;
      end
   end

   // ID/EX payload
   always_ff @(posedge clk) begin
      if (enable) begin
         rs1_data <= rdata_1;
         rs2_data <= rdata_2;
         imm      <= dec_imm;
         funct3   <= if_id_instr[funct3_lsb +: 3];
         funct7   <= if_id_instr[funct7_lsb +: 7];
      end
   end

endmodule

/* src/execute_stage.sv */
// EX/MEM result is preferred over MEM/WB; store data takes the forwarded rs2 like any operand
module execute_stage (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           enable,
   input  cpu_pkg::alu_op_e               alu_op,
   input  logic                           alu_src,
   input  logic                           mem_read,
   input  logic                           mem_write,
   input  logic                           mem_to_reg,
   input  logic                           reg_write,
   input  logic [cpu_pkg::xlen-1:0]       rs1_data,
   input  logic [cpu_pkg::xlen-1:0]       rs2_data,
   input  logic [cpu_pkg::xlen-1:0]       imm,
   input  logic [cpu_pkg::reg_addr_w-1:0] rs1,
   input  logic [cpu_pkg::reg_addr_w-1:0] rs2,
   input  logic [cpu_pkg::reg_addr_w-1:0] rd,
   input  logic [2:0]                     funct3,
   input  logic [6:0]                     funct7,
   input  logic                           wb_reg_write,
   input  logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
   input  logic [cpu_pkg::xlen-1:0]       wb_data,
   output logic [cpu_pkg::xlen-1:0]       ex_mem_alu_out,
   output logic [cpu_pkg::xlen-1:0]       ex_mem_store_data,
   output logic [cpu_pkg::reg_addr_w-1:0] ex_mem_rd,
   output logic                           ex_mem_reg_write,
   output logic                           ex_mem_mem_read,
   output logic                           ex_mem_mem_write,
   output logic                           ex_mem_mem_to_reg
);
   import cpu_pkg::*;

   fwd_sel_e        fwd_a;
   fwd_sel_e        fwd_b;
   alu_ctrl_e       alu_ctrl;
   logic [xlen-1:0] operand_a;
   logic [xlen-1:0] rs2_fwd;
   logic [xlen-1:0] operand_b;
   logic [xlen-1:0] alu_res;

   function automatic fwd_sel_e fwd_select(input logic [reg_addr_w-1:0] src,
                                           input logic mem_wr,
                                           input logic [reg_addr_w-1:0] mem_rd,
                                           input logic wb_wr,
                                           input logic [reg_addr_w-1:0] wb_dst);
      if (mem_wr && (mem_rd != '0) && (mem_rd == src)) begin
         return fwd_mem;
      end else if (wb_wr && (wb_dst != '0) && (wb_dst == src)) begin
         return fwd_wb;
      end
      return fwd_none;
   endfunction

   assign fwd_a = fwd_select(rs1, ex_mem_reg_write, ex_mem_rd, wb_reg_write, wb_rd);
   assign fwd_b = fwd_select(rs2, ex_mem_reg_write, ex_mem_rd, wb_reg_write, wb_rd);

   always_comb begin
      case (fwd_a)
         fwd_mem: operand_a = ex_mem_alu_out;
         fwd_wb:  operand_a = wb_data;
         default: operand_a = rs1_data;
      endcase
      case (fwd_b)
         fwd_mem: rs2_fwd = ex_mem_alu_out;
         fwd_wb:  rs2_fwd = wb_data;
         default: rs2_fwd = rs2_data;
      endcase
   end

   assign operand_b = alu_src ? imm : rs2_fwd;

   // addi only needs funct3; funct7 is meaningful for R-type
   always_comb begin
      alu_ctrl = alu_add;
      if (alu_op == alu_op_rtype || alu_op == alu_op_itype) begin
         case (funct3)
            funct3_and: alu_ctrl = alu_and;
            funct3_or:  alu_ctrl = alu_or;
            funct3_add: begin
               if (alu_op == alu_op_rtype && funct7 == funct7_sub) begin
                  alu_ctrl = alu_sub;
               end
            end
            default: ;
         endcase
      end
   end

   always_comb begin
      case (alu_ctrl)
         alu_and: alu_res = operand_a & operand_b;
         alu_or:  alu_res = operand_a | operand_b;
         alu_sub: alu_res = operand_a - operand_b;
         default: alu_res = operand_a + operand_b;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem_rd         <= '0;
         ex_mem_reg_write  <= 1'b0;
         ex_mem_mem_read   <= 1'b0;
         ex_mem_mem_write  <= 1'b0;
         ex_mem_mem_to_reg <= 1'b0;
      end else if (enable) begin
         ex_mem_rd         <= rd;
         ex_mem_reg_write  <= reg_write;
         ex_mem_mem_read   <= mem_read;
         ex_mem_mem_write  <= mem_write;
         ex_mem_mem_to_reg <= mem_to_reg;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         ex_mem_alu_out    <= alu_res;
         ex_mem_store_data <= rs2_fwd;
      end
   end

endmodule

/* src/memory_stage.sv */
// Data memory read is combinational at the ALU address; host port is for use with enable low
module memory_stage (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           enable,
   input  logic [cpu_pkg::xlen-1:0]       ex_mem_alu_out,
   input  logic [cpu_pkg::xlen-1:0]       ex_mem_store_data,
   input  logic [cpu_pkg::reg_addr_w-1:0] ex_mem_rd,
   input  logic                           ex_mem_reg_write,
   input  logic                           ex_mem_mem_read,
   input  logic                           ex_mem_mem_write,
   input  logic                           ex_mem_mem_to_reg,
   input  logic [cpu_pkg::xlen-1:0]       addr_ext_2,
   input  logic                           wen_ext_2,
   input  logic                           ren_ext_2,
   input  logic [cpu_pkg::xlen-1:0]       wdata_ext_2,
   output logic [cpu_pkg::xlen-1:0]       rdata_ext_2,
   output logic                           wb_reg_write,
   output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
   output logic [cpu_pkg::xlen-1:0]       wb_data
);
   import cpu_pkg::*;

   logic [xlen-1:0] mem_rdata;
   logic [xlen-1:0] mem_wb_load;
   logic [xlen-1:0] mem_wb_alu_out;
   logic            mem_wb_mem_to_reg;

   sram_dual_port #(
      .data_w(xlen),
      .addr_w(dmem_addr_w)
   ) data_mem (
      .clk      (clk),
      .arst_n   (arst_n),
      .addr     (ex_mem_alu_out),
      .wen      (ex_mem_mem_write && enable),
      .wdata    (ex_mem_store_data),
      .rdata    (mem_rdata),
      .addr_ext (addr_ext_2),
      .wen_ext  (wen_ext_2),
      .ren_ext  (ren_ext_2),
      .wdata_ext(wdata_ext_2),
      .rdata_ext(rdata_ext_2)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_reg_write      <= 1'b0;
         wb_rd             <= '0;
         mem_wb_mem_to_reg <= 1'b0;
      end else if (enable) begin
         wb_reg_write      <= ex_mem_reg_write;
         wb_rd             <= ex_mem_rd;
         mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
      end
   end

   // Load data only captured for loads
   always_ff @(posedge clk) begin
      if (enable) begin
         mem_wb_load    <= ex_mem_mem_read ? mem_rdata : '0;
         mem_wb_alu_out <= ex_mem_alu_out;
      end
   end

   assign wb_data = mem_wb_mem_to_reg ? mem_wb_load : mem_wb_alu_out;

endmodule

/* src/cpu.sv */
// Five-stage RV64 subset core with no branches; host memory ports only while enable is low
module cpu (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        enable,
   input  logic [63:0] addr_ext,
   input  logic        wen_ext,
   input  logic        ren_ext,
   input  logic [31:0] wdata_ext,
   output logic [31:0] rdata_ext,
   input  logic [63:0] addr_ext_2,
   input  logic        wen_ext_2,
   input  logic        ren_ext_2,
   input  logic [63:0] wdata_ext_2,
   output logic [63:0] rdata_ext_2
);
   import cpu_pkg::*;

   // IF/ID
   logic [ilen-1:0]       if_id_instr;
   logic [xlen-1:0]       if_id_pc;
   logic                  stall;

   // ID/EX
   alu_op_e               alu_op;
   logic                  alu_src;
   logic                  mem_read;
   logic                  mem_write;
   logic                  mem_to_reg;
   logic                  reg_write;
   logic [xlen-1:0]       rs1_data;
   logic [xlen-1:0]       rs2_data;
   logic [xlen-1:0]       imm;
   logic [reg_addr_w-1:0] rs1;
   logic [reg_addr_w-1:0] rs2;
   logic [reg_addr_w-1:0] rd;
   logic [2:0]            funct3;
   logic [6:0]            funct7;

   // EX/MEM
   logic [xlen-1:0]       ex_mem_alu_out;
   logic [xlen-1:0]       ex_mem_store_data;
   logic [reg_addr_w-1:0] ex_mem_rd;
   logic                  ex_mem_reg_write;
   logic                  ex_mem_mem_read;
   logic                  ex_mem_mem_write;
   logic                  ex_mem_mem_to_reg;

   // Write-back
   logic                  wb_reg_write;
   logic [reg_addr_w-1:0] wb_rd;
   logic [xlen-1:0]       wb_data;

   fetch_stage if_stage (
      .clk(clk), .arst_n(arst_n), .enable(enable), .stall(stall),
      .addr_ext(addr_ext), .wen_ext(wen_ext), .ren_ext(ren_ext),
      .wdata_ext(wdata_ext), .rdata_ext(rdata_ext),
      .if_id_instr(if_id_instr), .if_id_pc(if_id_pc)
   );

   decode_stage id_stage (
      .clk(clk), .arst_n(arst_n), .enable(enable),
      .if_id_instr(if_id_instr), .if_id_pc(if_id_pc),
      .wb_reg_write(wb_reg_write), .wb_rd(wb_rd), .wb_data(wb_data),
      .stall(stall), .alu_op(alu_op), .alu_src(alu_src),
      .mem_read(mem_read), .mem_write(mem_write), .mem_to_reg(mem_to_reg),
      .reg_write(reg_write), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
      .rs1(rs1), .rs2(rs2), .rd(rd), .funct3(funct3), .funct7(funct7)
   );

   execute_stage ex_stage (
      .clk(clk), .arst_n(arst_n), .enable(enable),
      .alu_op(alu_op), .alu_src(alu_src), .mem_read(mem_read),
      .mem_write(mem_write), .mem_to_reg(mem_to_reg), .reg_write(reg_write),
      .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
      .rs1(rs1), .rs2(rs2), .rd(rd), .funct3(funct3), .funct7(funct7),
      .wb_reg_write(wb_reg_write), .wb_rd(wb_rd), .wb_data(wb_data),
      .ex_mem_alu_out(ex_mem_alu_out), .ex_mem_store_data(ex_mem_store_data),
      .ex_mem_rd(ex_mem_rd), .ex_mem_reg_write(ex_mem_reg_write),
      .ex_mem_mem_read(ex_mem_mem_read), .ex_mem_mem_write(ex_mem_mem_write),
      .ex_mem_mem_to_reg(ex_mem_mem_to_reg)
   );

   memory_stage mem_stage (
      .clk(clk), .arst_n(arst_n), .enable(enable),
      .ex_mem_alu_out(ex_mem_alu_out), .ex_mem_store_data(ex_mem_store_data),
      .ex_mem_rd(ex_mem_rd), .ex_mem_reg_write(ex_mem_reg_write),
      .ex_mem_mem_read(ex_mem_mem_read), .ex_mem_mem_write(ex_mem_mem_write),
      .ex_mem_mem_to_reg(ex_mem_mem_to_reg),
      .addr_ext_2(addr_ext_2), .wen_ext_2(wen_ext_2), .ren_ext_2(ren_ext_2),
      .wdata_ext_2(wdata_ext_2), .rdata_ext_2(rdata_ext_2),
      .wb_reg_write(wb_reg_write), .wb_rd(wb_rd), .wb_data(wb_data)
   );

endmodule

/* test/tb_cpu.sv */
// Programs use x0-x7 only and fit in the first 80 instruction words; data model covers entries 0-63
module tb_cpu;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int imem_load_words  = 80;
   localparam int preload_entries  = 32;
   localparam int exec_cycles      = 70;
   localparam int readback_entries = 39;
   // Six runs of about 230 cycles, two port tests and one pause of up to 20 cycles
   localparam int timeout_cycles   = 2000;

   logic        clk;
   logic        arst_n;
   logic        enable;
   logic [63:0] addr_ext;
   logic        wen_ext;
   logic        ren_ext;
   logic [31:0] wdata_ext;
   logic [31:0] rdata_ext;
   logic [63:0] addr_ext_2;
   logic        wen_ext_2;
   logic        ren_ext_2;
   logic [63:0] wdata_ext_2;
   logic [63:0] rdata_ext_2;

   logic [31:0] prog[$];
   logic [63:0] model_regs[32];
   logic [63:0] model_mem[64];
   int          cycle_count;
   int          run;

   cpu uut (
      .clk(clk), .arst_n(arst_n), .enable(enable),
      .addr_ext(addr_ext), .wen_ext(wen_ext), .ren_ext(ren_ext),
      .wdata_ext(wdata_ext), .rdata_ext(rdata_ext),
      .addr_ext_2(addr_ext_2), .wen_ext_2(wen_ext_2), .ren_ext_2(ren_ext_2),
      .wdata_ext_2(wdata_ext_2), .rdata_ext_2(rdata_ext_2)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout after %0d cycles, the test did not finish", cycle_count);
         $display("Simulation failed");
         $fatal(1);
      end
   end

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("error at %0d ns: %s = %h, expected %h", $time, name, actual, expected);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   // RISC-V encodings with x0 as the base of loads and stores
   function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] ld_word(input logic [4:0] rd, input logic [11:0] off);
      return {off, 5'd0, 3'b011, rd, 7'b0000011};
   endfunction

   function automatic logic [31:0] sd_word(input logic [4:0] rs2, input logic [11:0] off);
      return {off[11:5], rs2, 5'd0, 3'b011, off[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] random_instr();
      int         kind;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [11:0] off;
      kind = $urandom_range(6);
      rd   = 5'($urandom_range(7));
      rs1  = 5'($urandom_range(7));
      rs2  = 5'($urandom_range(7));
      off  = 12'(8 * $urandom_range(31));
      case (kind)
         0: return rtype_word(7'h00, 3'b000, rd, rs1, rs2);
         1: return rtype_word(7'h20, 3'b000, rd, rs1, rs2);
         2: return rtype_word(7'h00, 3'b111, rd, rs1, rs2);
         3: return rtype_word(7'h00, 3'b110, rd, rs1, rs2);
         4: return addi_word(rd, rs1, 12'($urandom_range(4095)));
         5: return ld_word(rd, off);
         default: return sd_word(rs2, off);
      endcase
   endfunction

   // x1-x7 end up at byte addresses 256 to 304, entries 32-38
   task automatic append_final_stores();
      for (int i = 1; i < 8; i++) begin
         prog.push_back(sd_word(5'(i), 12'(256 + 8 * (i - 1))));
      end
   endtask

   task automatic build_random_program();
      prog = {};
      for (int i = 0; i < 40; i++) begin
         prog.push_back(random_instr());
      end
      append_final_stores();
   endtask

   // Back-to-back dependencies and stores of a just-computed value
   task automatic build_forwarding_program();
      prog = {};
      prog.push_back(addi_word(1, 0, 12'd100));
      prog.push_back(addi_word(2, 1, 12'd23));
      prog.push_back(rtype_word(7'h00, 3'b000, 3, 1, 2));
      prog.push_back(rtype_word(7'h20, 3'b000, 4, 3, 1));
      prog.push_back(sd_word(4, 12'd8));
      prog.push_back(rtype_word(7'h00, 3'b111, 5, 4, 3));
      prog.push_back(rtype_word(7'h00, 3'b110, 6, 5, 2));
      prog.push_back(addi_word(7, 6, 12'hffb));
      prog.push_back(sd_word(7, 12'd16));
      prog.push_back(rtype_word(7'h20, 3'b000, 1, 7, 4));
      append_final_stores();
   endtask

   task automatic build_load_use_program();
      prog = {};
      prog.push_back(ld_word(1, 12'd16));
      prog.push_back(rtype_word(7'h00, 3'b000, 2, 1, 1));
      prog.push_back(sd_word(2, 12'd24));
      prog.push_back(ld_word(3, 12'd32));
      prog.push_back(sd_word(3, 12'd40));
      prog.push_back(ld_word(4, 12'd48));
      prog.push_back(addi_word(5, 4, 12'd7));
      prog.push_back(rtype_word(7'h20, 3'b000, 6, 5, 4));
      prog.push_back(ld_word(7, 12'd8));
      prog.push_back(rtype_word(7'h00, 3'b110, 7, 7, 6));
      append_final_stores();
   endtask

   // Sequential instruction-set model of the program in prog
   task automatic model_execute();
      logic [31:0] w;
      logic [4:0]  rd;
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] imm_i;
      logic [63:0] imm_s;
      logic [63:0] res;
      logic        wr;
      for (int k = 0; k < prog.size(); k++) begin
         w     = prog[k];
         rd    = w[11:7];
         a     = model_regs[w[19:15]];
         b     = model_regs[w[24:20]];
         imm_i = {{52{w[31]}}, w[31:20]};
         imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
         res   = '0;
         wr    = 1'b0;
         case (w[6:0])
            7'b0110011: begin
               wr = 1'b1;
               case (w[14:12])
                  3'b111:  res = a & b;
                  3'b110:  res = a | b;
                  default: res = (w[31:25] == 7'h20) ? a - b : a + b;
               endcase
            end
            7'b0010011: begin
               wr  = 1'b1;
               res = a + imm_i;
            end
            7'b0000011: begin
               wr  = 1'b1;
               res = model_mem[(a + imm_i) >> 3];
            end
            7'b0100011: model_mem[(a + imm_s) >> 3] = b;
            default: ;
         endcase
         if (wr && rd != 0) begin
            model_regs[rd] = res;
         end
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      arst_n = 1'b0;
      enable = 1'b0;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
   endtask

   task automatic write_imem(input int word, input logic [31:0] data);
      addr_ext  = 64'(word * 4);
      wdata_ext = data;
      wen_ext   = 1'b1;
      @(negedge clk);
      wen_ext   = 1'b0;
   endtask

   task automatic write_dmem(input int entry, input logic [63:0] data);
      addr_ext_2  = 64'(entry * 8);
      wdata_ext_2 = data;
      wen_ext_2   = 1'b1;
      @(negedge clk);
      wen_ext_2   = 1'b0;
   endtask

   task automatic imem_port_test();
      logic [31:0] words[16];
      int          base;
      base = $urandom_range(495);
      for (int i = 0; i < 16; i++) begin
         words[i] = $urandom;
         write_imem(base + i, words[i]);
      end
      for (int i = 0; i < 16; i++) begin
         addr_ext = 64'((base + i) * 4);
         ren_ext  = 1'b1;
         @(negedge clk);
         check_value($sformatf("rdata_ext[%0d]", base + i), 64'(rdata_ext), 64'(words[i]));
      end
      // Output holds once the strobe is gone
      ren_ext  = 1'b0;
      addr_ext = 64'(base * 4);
      @(negedge clk);
      check_value("rdata_ext", 64'(rdata_ext), 64'(words[15]));
   endtask

   task automatic dmem_port_test();
      logic [63:0] dwords[16];
      for (int i = 0; i < 16; i++) begin
         dwords[i] = {$urandom, $urandom};
         write_dmem(40 + i, dwords[i]);
      end
      for (int i = 0; i < 16; i++) begin
         addr_ext_2 = 64'((40 + i) * 8);
         ren_ext_2  = 1'b1;
         @(negedge clk);
         check_value($sformatf("rdata_ext_2[%0d]", 40 + i), rdata_ext_2, dwords[i]);
      end
      ren_ext_2  = 1'b0;
      addr_ext_2 = '0;
      @(negedge clk);
      check_value("rdata_ext_2", rdata_ext_2, dwords[15]);
   endtask

   // Load, preload, run, read back and compare with the model
   task automatic run_program(input bit pause);
      logic [63:0] value;
      int          pause_len;
      apply_reset();
      for (int i = 0; i < imem_load_words; i++) begin
         write_imem(i, (i < prog.size()) ? prog[i] : 32'h0);
      end
      for (int i = 0; i < 64; i++) begin
         model_mem[i] = '0;
      end
      for (int i = 0; i < preload_entries; i++) begin
         value        = {$urandom, $urandom};
         model_mem[i] = value;
         write_dmem(i, value);
      end
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end
      model_execute();
      enable = 1'b1;
      for (int i = 0; i < exec_cycles; i++) begin
         if (pause && i == 30) begin
            pause_len = $urandom_range(20, 5);
            enable    = 1'b0;
            repeat (pause_len) @(negedge clk);
            enable    = 1'b1;
         end
         @(negedge clk);
      end
      enable = 1'b0;
      for (int i = 0; i < readback_entries; i++) begin
         addr_ext_2 = 64'(i * 8);
         ren_ext_2  = 1'b1;
         @(negedge clk);
         check_value($sformatf("dmem[%0d]", i), rdata_ext_2, model_mem[i]);
      end
      ren_ext_2 = 1'b0;
   endtask

   initial begin
      clk         = 1'b0;
      arst_n      = 1'b0;
      enable      = 1'b0;
      addr_ext    = '0;
      wen_ext     = 1'b0;
      ren_ext     = 1'b0;
      wdata_ext   = '0;
      addr_ext_2  = '0;
      wen_ext_2   = 1'b0;
      ren_ext_2   = 1'b0;
      wdata_ext_2 = '0;
      cycle_count = 0;
      void'($urandom(30));

      apply_reset();
      imem_port_test();
      dmem_port_test();

      // Last random run gets the enable pause
      for (run = 0; run < 4; run++) begin
         build_random_program();
         run_program(run == 3);
      end

      build_forwarding_program();
      run_program(1'b0);
      build_load_use_program();
      run_program(1'b0);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* verilog.f */
src/cpu_pkg.sv
src/sram_dual_port.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu.sv
test/tb_cpu.sv

/* Bender.yml */
package:
  name: rv64_pipeline

sources:
  - src/cpu_pkg.sv
  - src/sram_dual_port.sv
  - src/register_file.sv
  - src/fetch_stage.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/memory_stage.sv
  - src/cpu.sv
  - target: test
    files:
      - test/tb_cpu.sv
